//--- files.f
+incdir+src
src/fifoPkg.sv
src/bitsPkg.sv
src/fifoReadIf.sv
src/wordFifo.sv
src/bitExtractor.sv
src/bitsUnpacker.sv
testbench/bitsUnpacker_assertions.sv
testbench/bitsUnpackerTb.sv

//--- Bender.yml
package:
  name: bits_unpacker

sources:
  - include_dirs:
      - src
    files:
      - src/fifoPkg.sv
      - src/bitsPkg.sv
      - src/fifoReadIf.sv
      - src/wordFifo.sv
      - src/bitExtractor.sv
      - src/bitsUnpacker.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/bitsUnpacker_assertions.sv
      - testbench/bitsUnpackerTb.sv

//--- testbench/bitsUnpackerTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bits_params.svh"

module bitsUnpackerTb;

    import bitsPkg::*;

    // About 400 random requests at under 10 cycles each, plus a drain of 34 words.
    localparam int MaxCycles = 20000;

    logic     Clk = 1'b0;
    logic     RstN, clear, pushin, reqin;
    wordT     datain;
    fieldLenT reqlen;
    logic     pushout, full;
    fieldLenT lenout;
    fieldT    dataout;

    bit    bitQ [$];             // Every accepted stream bit, oldest first.
    int    lenQ [$];             // Lengths of requests not yet answered.
    int    issued    = 0;
    int    doneCount = 0;
    int    cycleCount = 0;
    string testName  = "reset";
    logic [31:0] lcgState = 32'h55ac;

    bitsUnpacker uut (
        .Clk(Clk), .RstN(RstN), .clear(clear), .pushin(pushin), .datain(datain),
        .reqin(reqin), .reqlen(reqlen), .pushout(pushout), .lenout(lenout),
        .dataout(dataout), .full(full)
    );

    always #20 Clk = ~Clk; // 40 ns period.

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and helpers.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Next len bits of the stream, MSB-first, right-aligned.
    function automatic fieldT refField(input int len);
        fieldT f;
        f = '0;
        for (int i = 0; i < len; i++) begin
            f = {f[`BITS_FIELD_WIDTH-2:0], bitQ.pop_front()};
        end
        return f;
    endfunction

    task automatic abortRun();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error.");
    endtask

    task automatic pushWord(input wordT w);
        if (!full) begin // A push while full is lost.
            for (int i = `BITS_WORD_WIDTH - 1; i >= 0; i--) begin
                bitQ.push_back(w[i]);
            end
        end
        pushin = 1'b1;
        datain = w;
        @(posedge Clk); #2;
        pushin = 1'b0;
    endtask

    task automatic issueRequest(input int len);
        lenQ.push_back(len);
        issued++;
        reqin  = 1'b1;
        reqlen = fieldLenT'(len);
        @(posedge Clk); #2;
        reqin  = 1'b0;
    endtask

    task automatic waitAnswer();
        wait (doneCount == issued);
        @(posedge Clk); #2;
    endtask

    task automatic requestField(input int len);
        issueRequest(len);
        waitAnswer();
    endtask

    task automatic clearStream();
        clear = 1'b1;
        @(posedge Clk); #2;
        clear = 1'b0;
        bitQ.delete(); // Old words are gone.
    endtask

    task automatic idleCycles(input int n);
        repeat (n) @(posedge Clk);
        #2;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Answer checking and timeout.
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge Clk) begin
        int    expLen;
        fieldT expField;
        if (!RstN && pushout) begin
            assert (lenQ.size() != 0) else begin
                $display("Answer strobe in %s came with no request outstanding.", testName);
                abortRun();
            end
            expLen   = lenQ.pop_front();
            expField = refField(expLen);
            assert (lenout == fieldLenT'(expLen)) else begin
                $display("Fail %s: lenout expected %0d, actual %0d", testName, expLen, lenout);
                abortRun();
            end
            assert (dataout == expField) else begin
                $display("Fail %s: dataout expected %h, actual %h", testName, expField, dataout);
                abortRun();
            end
            doneCount++;
        end
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout in %s: the DUT stopped answering.", testName);
            abortRun();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        wordT r;
        int   len;
        int   asrtFails;
        RstN   = 1'b1;
        clear  = 1'b0;
        pushin = 1'b0;
        reqin  = 1'b0;
        datain = '0;
        reqlen = '0;
        repeat (5) @(posedge Clk);
        #2 RstN = 1'b0;
        assert (!pushout && !full) else begin
            $display("Fail reset: pushout, full expected 0 0, actual %b %b", pushout, full);
            abortRun();
        end

        testName = "fixed_fields"; // 96 bits in fields that straddle words.
        pushWord(32'hDEAD_BEEF);
        pushWord(32'h1234_5678);
        pushWord(32'hA5A5_F00F);
        requestField(13);
        requestField(7);
        requestField(15);
        requestField(12);
        requestField(9);
        requestField(15);
        requestField(14);
        requestField(11);

        testName = "pending_wait";
        clearStream();
        issueRequest(15); // Nothing pushed yet.
        idleCycles(4);
        assert (doneCount < issued) else begin
            $display("Request in %s completed before its bits were pushed.", testName);
            abortRun();
        end
        pushWord(32'hC3A5_0F96);
        waitAnswer();
        requestField(15);
        issueRequest(12); // Only two bits are left so it waits again.
        idleCycles(3);
        pushWord(32'h7E81_3C5A);
        waitAnswer();

        testName = "zero_length";
        clearStream();
        requestField(0); // Served with no bits at all.
        pushWord(32'h9F0E_6B21);
        requestField(9);
        requestField(0);
        requestField(3);

        testName = "full_level";
        clearStream();
        for (int k = 1; k <= 35; k++) begin
            pushWord(nextRandom());
            assert (full == (k >= 34)) else begin
                $display("Fail %s: full after push %0d expected %0b, actual %0b",
                         testName, k, k >= 34, full);
                abortRun();
            end
        end
        while (bitQ.size() > 0) requestField(bitQ.size() > 15 ? 15 : bitQ.size());
        pushWord(32'h0F1E_2D3C); // Shows whether word 35 slipped in.
        requestField(15);

        testName = "clear_flush";
        pushWord(32'hFFFF_FFFF);
        requestField(5);
        clearStream();
        pushWord(32'h0123_4567);
        pushWord(32'h89AB_CDEF);
        for (int i = 0; i < 4; i++) requestField(15);

        testName = "random_stream";
        clearStream();
        for (int n = 0; n < 400; n++) begin
            r = nextRandom();
            if (r[3:2] == 2'b00) pushWord(nextRandom());
            len = 1 + (r[15:8] % 15);
            issueRequest(len);
            while (doneCount != issued && bitQ.size() < len) pushWord(nextRandom());
            waitAnswer();
        end

        asrtFails = uut.uExtractor.uExtractorChecks.failCount +
                    uut.uFifo.uFifoChecks.failCount;
        if (asrtFails == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("Bound protocol assertions failed %0d times.", asrtFails);
            abortRun();
        end
    end

endmodule : bitsUnpackerTb

`default_nettype wire

//--- testbench/bitsUnpacker_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol and flag checks, bound once into the extractor and once into the FIFO.
// Each instance ties off the half it does not watch.
module bitsUnpackerAssertions (
    input logic               Clk,
    input logic               RstN,
    input logic               reqin,   // Request strobe.
    input logic               pending, // Request waiting for bits.
    input logic               pushout, // Answer strobe.
    input logic               empty,
    input logic               first,
    input logic               full,
    input fifoPkg::fifoCountT count    // FIFO fill count.
);

    import fifoPkg::*;

    int failCount = 0; // Assertion failures so far.

    ////////////////////////////////////////////////////////////////////////////
    // Request side.
    ////////////////////////////////////////////////////////////////////////////

    noReqWhilePending: assert property (@(posedge Clk) disable iff (RstN)
        reqin |-> !pending)
        else begin
            failCount++;
            $error("New request arrived while another one was pending.");
        end

    pushoutOneCycle: assert property (@(posedge Clk) disable iff (RstN)
        pushout |=> !pushout)
        else begin
            failCount++;
            $error("pushout stayed high for more than one cycle.");
        end

    ////////////////////////////////////////////////////////////////////////////
    // FIFO flags.
    ////////////////////////////////////////////////////////////////////////////

    notEmptyAndFull: assert property (@(posedge Clk) disable iff (RstN)
        !(empty && full))
        else begin
            failCount++;
            $error("FIFO flags empty and full were set together.");
        end

    firstMatchesCount: assert property (@(posedge Clk) disable iff (RstN)
        first == (count == fifoCountT'(1)))
        else begin
            failCount++;
            $error("FIFO flag first disagrees with a fill count of one.");
        end

endmodule : bitsUnpackerAssertions

// Request rules live in the extractor.
bind bitExtractor bitsUnpackerAssertions uExtractorChecks (
    .Clk     (Clk),
    .RstN    (RstN),
    .reqin   (reqin),
    .pending (pending),
    .pushout (pushout),
    .empty   (1'b0),
    .first   (1'b0),
    .full    (1'b0),
    .count   ('0)
);

// Flag rules live in the FIFO.
bind wordFifo bitsUnpackerAssertions uFifoChecks (
    .Clk     (Clk),
    .RstN    (RstN),
    .reqin   (1'b0),
    .pending (1'b0),
    .pushout (1'b0),
    .empty   (flags.empty),
    .first   (flags.first),
    .full    (flags.full),
    .count   (count)
);

`default_nettype wire

//--- src/bitsUnpacker.sv
`timescale 1ns/1ps
`default_nettype none

// Bitstream unpacker top.
// Producer pushes 32-bit words; consumer asks for fields of 0 to 15 bits,
// cut MSB-first from the stream in push order.
module bitsUnpacker (
    input  logic              Clk,
    input  logic              RstN,    // Asynchronous, active high.
    input  logic              clear,   // Flushes words and requests.
    input  logic              pushin,  // Word strobe.
    input  bitsPkg::wordT     datain,  // Word to push.
    input  logic              reqin,   // Field request strobe.
    input  bitsPkg::fieldLenT reqlen,  // Requested length.
    output logic              pushout, // Field answer strobe.
    output bitsPkg::fieldLenT lenout,  // Answered length.
    output bitsPkg::fieldT    dataout, // Answered field.
    output logic              full     // Input back-pressure level.
);

    ////////////////////////////////////////////////////////////////////////////
    // FIFO to extractor link.
    ////////////////////////////////////////////////////////////////////////////

    fifoReadIf rdIf ();

    // Word buffer.
    wordFifo uFifo (
        .Clk      (Clk),
        .RstN     (RstN),
        .clear    (clear),
        .push     (pushin),
        .pushData (datain),
        .rd       (rdIf.fifoSide)
    );

    // Field server.
    bitExtractor uExtractor (
        .Clk     (Clk),
        .RstN    (RstN),
        .clear   (clear),
        .reqin   (reqin),
        .reqlen  (reqlen),
        .rd      (rdIf.consumerSide),
        .pushout (pushout),
        .lenout  (lenout),
        .dataout (dataout)
    );

    assign full = rdIf.full; // Producer must hold pushes while high.

endmodule : bitsUnpacker

`default_nettype wire

//--- src/bitExtractor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bits_params.svh"

// Bit accumulator between the word FIFO and the field consumer.
// Words are appended below the valid bits of an MSB-aligned register;
// fields are taken from the top.
module bitExtractor (
    input  logic              Clk,
    input  logic              RstN,    // Asynchronous, active high.
    input  logic              clear,   // Drops bits and pending request.
    input  logic              reqin,   // Field request strobe.
    input  bitsPkg::fieldLenT reqlen,  // Length of the request.
    fifoReadIf.consumerSide   rd,
    output logic              pushout, // One-cycle answer strobe.
    output bitsPkg::fieldLenT lenout,  // Length of the answered field.
    output bitsPkg::fieldT    dataout  // Field bits, right-aligned.
);

    import bitsPkg::*;

    localparam int AccW  = `BITS_ACC_WIDTH;
    localparam int WordW = `BITS_WORD_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // State.
    ////////////////////////////////////////////////////////////////////////////

    logic [AccW-1:0] acc;      // Valid bits sit at the top with zeros below.
    accCountT        accCount; // Number of valid bits in acc.
    logic            pending;  // A request waits for service.
    fieldLenT        pendLen;  // Its length.

    // Next-state terms.
    logic [AccW-1:0] shifted;      // acc after the served bits leave.
    logic [AccW-1:0] appended;     // New word placed below what remains.
    logic [AccW-1:0] accNext;
    accCountT        accCountNext;
    accCountT        takeLen;      // Bits removed this cycle.
    logic [AccW-1:0] topBits;      // Requested bits moved to the bottom.
    fieldT           fieldVal;
    logic            pull;         // Pop a word this cycle.
    logic            serve;        // Answer the pending request.

    ////////////////////////////////////////////////////////////////////////////
    // Word pulls and service decision.
    ////////////////////////////////////////////////////////////////////////////

    // Pull while at most one word is held, so a new word always fits.
    assign pull    = !rd.empty && (accCount <= accCountT'(WordW));
    assign rd.pop  = pull;

    // Length 0 is served at once.
    assign serve   = pending && (accCount >= accCountT'(pendLen));
    assign takeLen = serve ? accCountT'(pendLen) : '0;

    // Field extract. A shift of the full width yields zero for length 0.
    assign topBits  = acc >> (accCountT'(AccW) - accCountT'(pendLen));
    assign fieldVal = fieldT'(topBits); // Upper bits are already zero.

    // Shift out the served bits, then hang the new word below the rest.
    assign shifted  = acc << takeLen;
    assign appended = {rd.data, {WordW{1'b0}}} >> (accCount - takeLen);

    always_comb begin
        accNext      = shifted;
        accCountNext = accCount - takeLen;
        if (pull) begin
            accNext      = shifted | appended; // Bits below valid are zero.
            accCountNext = accCount - takeLen + accCountT'(WordW);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or posedge RstN) begin
        if (RstN) begin
            acc      <= '0;
            accCount <= '0;
            pending  <= 1'b0;
            pushout  <= 1'b0;
        end else if (clear) begin
            acc      <= '0; // Old stream is gone.
            accCount <= '0;
            pending  <= 1'b0; // Waiting request is dropped.
            pushout  <= 1'b0;
        end else begin
            acc      <= accNext;
            accCount <= accCountNext;
            pushout  <= serve; // Answer one edge after service.
            if (serve) begin
                pending <= 1'b0;
            end
            if (reqin) begin
                pending <= 1'b1; // Only legal while idle.
            end
        end
    end

    // Request length is held while pending.
    always_ff @(posedge Clk) begin
        if (reqin) begin
            pendLen <= reqlen;
        end
    end

    // Answer payload is valid while pushout is high.
    always_ff @(posedge Clk) begin
        if (serve) begin
            lenout  <= pendLen;
            dataout <= fieldVal;
        end
    end

endmodule : bitExtractor

`default_nettype wire

//--- src/wordFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "bits_params.svh"

// Word FIFO with combinational read port and registered status flags.
module wordFifo (
    input  logic          Clk,
    input  logic          RstN,     // Asynchronous, active high.
    input  logic          clear,    // Synchronous flush.
    input  logic          push,
    input  bitsPkg::wordT pushData,
    fifoReadIf.fifoSide   rd
);

    import bitsPkg::*;
    import fifoPkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Storage and pointers.
    ////////////////////////////////////////////////////////////////////////////

    wordT      mem [`BITS_FIFO_DEPTH]; // Word storage.
    fifoPtrT   wrPtr;                  // Next slot to write.
    fifoPtrT   rdPtr;                  // Oldest word.
    fifoCountT count;                  // Words stored.
    fifoFlagsT flags;                  // Registered status.

    logic pushEn;   // Push that is accepted.
    logic popEn;    // Pop that is accepted.
    logic pushOnly; // Count goes up.
    logic popOnly;  // Count goes down.

    assign pushEn   = push && !flags.full;   // Push while full is lost.
    assign popEn    = rd.pop && !flags.empty; // Pop while empty is ignored.
    assign pushOnly = pushEn && !popEn;
    assign popOnly  = popEn && !pushEn;

    // Read port shows the oldest word straight from the array.
    assign rd.data  = mem[rdPtr];
    assign rd.empty = flags.empty;
    assign rd.first = flags.first;
    assign rd.full  = flags.full;

    // Memory write.
    always_ff @(posedge Clk) begin
        if (pushEn && !clear) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers and fill count.
    always_ff @(posedge Clk or posedge RstN) begin
        if (RstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else if (clear) begin
            wrPtr <= '0; // Flush drops every stored word.
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) begin
                wrPtr <= wrPtr + fifoPtrT'(1); // Wraps at depth.
            end
            if (popEn) begin
                rdPtr <= rdPtr + fifoPtrT'(1);
            end
            if (pushOnly) begin
                count <= count + fifoCountT'(1);
            end else if (popOnly) begin
                count <= count - fifoCountT'(1);
            end
            // Push and pop together keep the count.
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Status flags.
    // Each flag moves from its neighbour and the coming operation, so
    // all five change on the same edge as the count.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or posedge RstN) begin
        if (RstN) begin
            flags <= '{empty: 1'b1, default: 1'b0};
        end else if (clear) begin
            flags <= '{empty: 1'b1, default: 1'b0}; // Back to empty state.
        end else begin
            // Empty.
            if (pushOnly) begin
                flags.empty <= 1'b0;
            end else if (popOnly && flags.first) begin
                flags.empty <= 1'b1; // Last word leaves.
            end

            // First marks one word stored.
            if ((flags.empty && pushOnly) ||
                (count == fifoCountT'(2) && popOnly)) begin
                flags.first <= 1'b1;
            end else if (flags.first && (pushOnly || popOnly)) begin
                flags.first <= 1'b0;
            end

            // Second to last marks two free slots.
            if ((count == fifoCountT'(`BITS_FIFO_DEPTH-3) && pushOnly) ||
                (flags.last && popOnly)) begin
                flags.sLast <= 1'b1;
            end else if (flags.sLast && (pushOnly || popOnly)) begin
                flags.sLast <= 1'b0;
            end

            // Last marks one free slot.
            if ((flags.sLast && pushOnly) || (flags.full && popOnly)) begin
                flags.last <= 1'b1;
            end else if (flags.last && (pushOnly || popOnly)) begin
                flags.last <= 1'b0;
            end

            // Full.
            if (flags.last && pushOnly) begin
                flags.full <= 1'b1;
            end else if (flags.full && popOnly) begin
                flags.full <= 1'b0;
            end
        end
    end

endmodule : wordFifo

`default_nettype wire

//--- src/fifoReadIf.sv
`timescale 1ns/1ps
`default_nettype none

// Read side of the word FIFO.
// The FIFO shows its oldest word on data at all times; the consumer pops it.
interface fifoReadIf;

    import bitsPkg::*;

    logic pop;   // Consumer takes the word on data.
    wordT data;  // Oldest stored word.
    logic empty; // Nothing stored, data is stale.
    logic first; // Exactly one word left.
    logic full;  // No room for another push.

    // Buffer end.
    modport fifoSide (
        input  pop,
        output data,
        output empty,
        output first,
        output full
    );

    // Reader end.
    modport consumerSide (
        output pop,
        input  data,
        input  empty,
        input  first,
        input  full
    );

endinterface : fifoReadIf

`default_nettype wire

//--- src/bitsPkg.sv
`default_nettype none

`include "bits_params.svh"

// Types for the bit stream and the fields cut from it.
package bitsPkg;

    // One stream word as pushed by the producer.
    typedef logic [`BITS_WORD_WIDTH-1:0] wordT;

    // Requested field length in bits.
    typedef logic [`BITS_LEN_WIDTH-1:0] fieldLenT;

    // Field as returned, right-aligned and zero above the length.
    typedef logic [`BITS_FIELD_WIDTH-1:0] fieldT;

    // Valid bit count of the accumulator, 0 up to the full width.
    typedef logic [$clog2(`BITS_ACC_WIDTH+1)-1:0] accCountT;

endpackage : bitsPkg

`default_nettype wire

//--- src/fifoPkg.sv
`default_nettype none

`include "bits_params.svh"

// Types for the word buffer: pointers, fill count and status flags.
package fifoPkg;

    // Read or write pointer into the memory array.
    typedef logic [`BITS_FIFO_AWIDTH-1:0] fifoPtrT;

    // Fill count is one bit wider so that a full FIFO fits.
    typedef logic [`BITS_FIFO_AWIDTH:0] fifoCountT;

    // Status flags are all active high.
    typedef struct packed {
        logic empty; // No words stored.
        logic first; // Exactly one word stored.
        logic sLast; // Room for two more words.
        logic last;  // Room for one more word.
        logic full;  // No room left.
    } fifoFlagsT;

endpackage : fifoPkg

`default_nettype wire

//--- src/bits_params.svh
`ifndef BITS_PARAMS_SVH
`define BITS_PARAMS_SVH

/////////////////////////////////////////////////////////////////////////////
// Stream word and FIFO geometry.
/////////////////////////////////////////////////////////////////////////////

`define BITS_WORD_WIDTH  32 // Width of one pushed word.
`define BITS_FIFO_DEPTH  32 // Number of FIFO entries.
`define BITS_FIFO_AWIDTH 5  // Pointer width so that 2**AWIDTH == DEPTH.

/////////////////////////////////////////////////////////////////////////////
// Field extraction.
/////////////////////////////////////////////////////////////////////////////

`define BITS_FIELD_WIDTH 15 // Right-aligned output field.
`define BITS_LEN_WIDTH   4  // Requested length, 0 to 15 bits.

// Two words of staging, so a pull and a serve never overflow.
`define BITS_ACC_WIDTH   64

`endif
